// ==== hw/saci_settings.svh ====
`ifndef SACI_SETTINGS_SVH
`define SACI_SETTINGS_SVH

// Data and address width of the accumulator machine
`define SACI_WORD_W 8

// Opcode field width, upper nibble of an instruction byte
`define SACI_OPC_W 4

// Program memory address width
// 128 words, the lower half of the address space
`define SACI_PROG_AW 7

// Address bit that selects the data byte
// Every upper address aliases the same byte
`define SACI_WINDOW_BIT 7

// Seven-segment display width, segments a to g
`define SACI_SEG_W 7

`endif

// ==== hw/saci_pkg.sv ====
`include "saci_settings.svh"

package saci_pkg;

    // Data byte or memory address
    typedef logic [`SACI_WORD_W-1:0] word_t;

    // Raw opcode in the instruction byte
    // Values not listed here halt the machine
    typedef enum logic [`SACI_OPC_W-1:0] {
        OPC_STA = 4'h1,
        OPC_LDA = 4'h2,
        OPC_ADD = 4'h3,
        OPC_HLT = 4'hf
    } opcode_e;

    // Translated opcode seen by the FSM
    typedef enum logic [1:0] {
        OP_HLT = 2'd0,
        OP_STA = 2'd1,
        OP_LDA = 2'd2,
        OP_ADD = 2'd3
    } op_e;

    // Sequencer states
    typedef enum logic [2:0] {
        FETCH   = 3'd0,
        OPERAND = 3'd1,
        LOAD    = 3'd2,
        ADD     = 3'd3,
        STORE   = 3'd4
    } state_e;

    // Control bundle from sequencer to datapath
    typedef struct packed {
        logic sel_pc;
        logic sel_mem;
        logic en_rem;
        logic write;
        logic op_add;
        logic en_ac;
        logic en_pc;
    } ctrl_t;

    // Program load strobe, one word per cycle while we is high
    typedef struct packed {
        logic                     we;
        logic [`SACI_PROG_AW-1:0] addr;
        word_t                    data;
    } prog_load_t;

endpackage

// ==== hw/saci_control.sv ====
`timescale 1ns/1ps
`include "saci_settings.svh"

module saci_control (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             run,
    input  saci_pkg::word_t  rd_data,
    output saci_pkg::ctrl_t  ctrl,
    output saci_pkg::state_e state,
    output logic             halted
);

    saci_pkg::state_e state_q;
    saci_pkg::state_e state_d;
    saci_pkg::op_e    op_live;
    saci_pkg::op_e    op_q;
    saci_pkg::op_e    op_cur;
    logic             in_fetch;
    logic             in_operand;
    logic             is_hlt;

    // Opcode translator, unknown codes fall to HLT
    always_comb begin
        case (saci_pkg::opcode_e'(rd_data[`SACI_WORD_W-1 -: `SACI_OPC_W]))
            saci_pkg::OPC_STA: op_live = saci_pkg::OP_STA;
            saci_pkg::OPC_LDA: op_live = saci_pkg::OP_LDA;
            saci_pkg::OPC_ADD: op_live = saci_pkg::OP_ADD;
            default:           op_live = saci_pkg::OP_HLT;
        endcase
    end

    assign in_fetch   = (state_q == saci_pkg::FETCH);
    assign in_operand = (state_q == saci_pkg::OPERAND);

    // Opcode byte is only on the bus during fetch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_q <= saci_pkg::OP_HLT;
        end else if (in_fetch) begin
            op_q <= op_live;
        end
    end

    // Live value in fetch, held value afterwards
    assign op_cur = in_fetch ? op_live : op_q;
    assign is_hlt = (op_cur == saci_pkg::OP_HLT);

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            saci_pkg::FETCH: begin
                // HLT parks here with the PC frozen
                if (!is_hlt) begin
                    state_d = saci_pkg::OPERAND;
                end
            end
            saci_pkg::OPERAND: begin
                case (op_cur)
                    saci_pkg::OP_STA: state_d = saci_pkg::STORE;
                    saci_pkg::OP_LDA: state_d = saci_pkg::LOAD;
                    saci_pkg::OP_ADD: state_d = saci_pkg::ADD;
                    default:          state_d = saci_pkg::FETCH;
                endcase
            end
            default: state_d = saci_pkg::FETCH;
        endcase
    end

    // State holds while run is low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= saci_pkg::FETCH;
        end else if (run) begin
            state_q <= state_d;
        end
    end

    // Moore selects, run-gated enables, Mealy en_pc
    always_comb begin
        ctrl         = '0;
        ctrl.sel_pc  = in_fetch || in_operand;
        ctrl.sel_mem = in_fetch || in_operand;
        ctrl.en_rem  = run && (in_fetch || in_operand);
        ctrl.write   = run && (state_q == saci_pkg::STORE);
        ctrl.op_add  = (state_q == saci_pkg::ADD);
        ctrl.en_ac   = run && (state_q == saci_pkg::LOAD || state_q == saci_pkg::ADD);
        ctrl.en_pc   = run && (in_fetch || in_operand) && !is_hlt;
    end

    assign state  = state_q;
    // Board LED, fetch sitting on a halt
    assign halted = in_fetch && is_hlt;

endmodule

// ==== hw/saci_datapath.sv ====
`timescale 1ns/1ps

module saci_datapath (
    input  logic            clk,
    input  logic            arst_n,
    input  saci_pkg::ctrl_t ctrl,
    input  saci_pkg::word_t rd_data,
    output saci_pkg::word_t mem_addr,
    output saci_pkg::word_t acc
);

    saci_pkg::word_t pc_q;
    saci_pkg::word_t rem_q;
    saci_pkg::word_t acc_q;
    saci_pkg::word_t pc_inc;
    saci_pkg::word_t pc_d;
    saci_pkg::word_t alu_out;

    // PC incrementer
    assign pc_inc = pc_q + 1'b1;

    // Next PC, incremented or a jump target from memory
    assign pc_d = ctrl.sel_pc ? pc_inc : rd_data;

    // ALU, add or pass
    // Sum wraps modulo 256, no carry out
    assign alu_out = ctrl.op_add ? saci_pkg::word_t'(rd_data + acc_q) : rd_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q  <= '0;
            rem_q <= '0;
            acc_q <= '0;
        end else begin
            if (ctrl.en_pc) begin
                pc_q <= pc_d;
            end
            // REM takes the operand address
            if (ctrl.en_rem) begin
                rem_q <= rd_data;
            end
            if (ctrl.en_ac) begin
                acc_q <= alu_out;
            end
        end
    end

    // Instruction stream from PC, data access from REM
    assign mem_addr = ctrl.sel_mem ? pc_q : rem_q;

    // Store data for STA
    assign acc = acc_q;

endmodule

// ==== hw/saci_memory.sv ====
`timescale 1ns/1ps
`include "saci_settings.svh"

module saci_memory (
    input  logic                 clk,
    input  logic                 arst_n,
    input  saci_pkg::prog_load_t load,
    input  saci_pkg::word_t      addr,
    input  saci_pkg::word_t      wr_data,
    input  logic                 write,
    output saci_pkg::word_t      rd_data,
    output saci_pkg::word_t      data_byte
);

    localparam int PROG_DEPTH = 1 << `SACI_PROG_AW;

    saci_pkg::word_t prog_mem [PROG_DEPTH];
    saci_pkg::word_t data_q;
    logic            upper;

    // Bit 7 splits program half from data window
    assign upper = addr[`SACI_WINDOW_BIT];

    // Program half, written from the load port only
    always_ff @(posedge clk) begin
        if (load.we) begin
            prog_mem[load.addr] <= load.data;
        end
    end

    // Single data byte aliased by every upper address
    // Stores to the program half are dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_q <= '0;
        end else if (write && upper) begin
            data_q <= wr_data;
        end
    end

    // Combinational read
    assign rd_data = upper ? data_q : prog_mem[addr[`SACI_PROG_AW-1:0]];

    // Raw tap for the display
    assign data_byte = data_q;

endmodule

// ==== hw/saci_hex_display.sv ====
`timescale 1ns/1ps
`include "saci_settings.svh"

module saci_hex_display (
    input  logic [3:0]             digit,
    output logic [`SACI_SEG_W-1:0] seg
);

    // Active-high segments, a in the MSB down to g in the LSB
    always_comb begin
        case (digit)
            4'h0: seg = 7'b1111110;
            4'h1: seg = 7'b0110000;
            4'h2: seg = 7'b1101101;
            4'h3: seg = 7'b1111001;
            4'h4: seg = 7'b0110011;
            4'h5: seg = 7'b1011011;
            4'h6: seg = 7'b1011111;
            4'h7: seg = 7'b1110000;
            4'h8: seg = 7'b1111111;
            4'h9: seg = 7'b1111011;
            // Letters, b and d in lower case
            4'ha: seg = 7'b1110111;
            4'hb: seg = 7'b0011111;
            4'hc: seg = 7'b1001110;
            4'hd: seg = 7'b0111101;
            4'he: seg = 7'b1001111;
            default: seg = 7'b1000111;
        endcase
    end

endmodule

// ==== hw/saci_top.sv ====
`timescale 1ns/1ps
`include "saci_settings.svh"

module saci_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   run,
    input  saci_pkg::prog_load_t   load,
    output logic [`SACI_SEG_W-1:0] addr_seg,
    output logic                   addr_msb,
    output logic [`SACI_SEG_W-1:0] data_seg,
    output saci_pkg::word_t        data_byte,
    output saci_pkg::state_e       state,
    output logic                   halted
);

    saci_pkg::ctrl_t ctrl;
    saci_pkg::word_t rd_data;
    saci_pkg::word_t mem_addr;
    saci_pkg::word_t acc;

    // Sequencer
    saci_control saci_control_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .run     (run),
        .rd_data (rd_data),
        .ctrl    (ctrl),
        .state   (state),
        .halted  (halted)
    );

    // PC, REM, accumulator
    saci_datapath saci_datapath_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .ctrl     (ctrl),
        .rd_data  (rd_data),
        .mem_addr (mem_addr),
        .acc      (acc)
    );

    // Program half plus data byte
    saci_memory saci_memory_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (load),
        .addr      (mem_addr),
        .wr_data   (acc),
        .write     (ctrl.write),
        .rd_data   (rd_data),
        .data_byte (data_byte)
    );

    // Low nibble of the bus address
    saci_hex_display addr_display_inst (
        .digit (mem_addr[3:0]),
        .seg   (addr_seg)
    );

    // Low nibble of the stored byte
    saci_hex_display data_display_inst (
        .digit (data_byte[3:0]),
        .seg   (data_seg)
    );

    // Upper half flag for the address LED
    assign addr_msb = mem_addr[`SACI_WINDOW_BIT];

endmodule

// ==== sim/saci_tb.sv ====
`timescale 1ns/1ps
`include "saci_settings.svh"

module saci_tb;

    localparam int PROG_WORDS  = 1 << `SACI_PROG_AW;
    localparam int NUM_TESTS   = 20;
    localparam int MAX_INSTR   = 40;
    localparam int CLK_NS      = 8;
    // Reset, full load, 5 cycles per instruction and slack
    localparam int TEST_CYCLES = 4 + PROG_WORDS + MAX_INSTR * 5 + 40;
    localparam int WATCHDOG_NS = 2 * NUM_TESTS * TEST_CYCLES * CLK_NS;

    logic                   clk;
    logic                   arst_n;
    logic                   run;
    saci_pkg::prog_load_t   load;
    logic [`SACI_SEG_W-1:0] addr_seg;
    logic                   addr_msb;
    logic [`SACI_SEG_W-1:0] data_seg;
    saci_pkg::word_t        data_byte;
    saci_pkg::state_e       state;
    logic                   halted;

    // Program image that is also the model's view of the lower half
    logic [7:0] image [PROG_WORDS];
    logic [7:0] exp_data;
    logic [7:0] exp_halt_pc;
    int         errors;
    int         seg_errors;
    int         tests_run;
    int         tests_failed;

    saci_top saci_top_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .load      (load),
        .addr_seg  (addr_seg),
        .addr_msb  (addr_msb),
        .data_seg  (data_seg),
        .data_byte (data_byte),
        .state     (state),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Segments a to g with a in the MSB
    function automatic logic [6:0] seg_of(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'h7e;
            4'h1: return 7'h30;
            4'h2: return 7'h6d;
            4'h3: return 7'h79;
            4'h4: return 7'h33;
            4'h5: return 7'h5b;
            4'h6: return 7'h5f;
            4'h7: return 7'h70;
            4'h8: return 7'h7f;
            4'h9: return 7'h7b;
            4'ha: return 7'h77;
            4'hb: return 7'h1f;
            4'hc: return 7'h4e;
            4'hd: return 7'h3d;
            4'he: return 7'h4f;
            default: return 7'h47;
        endcase
    endfunction

    task automatic report_mismatch(input string sig, input logic [7:0] exp, input logic [7:0] got);
        $display("FAIL t=%0t %s expected %02h got %02h", $time, sig, exp, got);
        errors++;
    endtask

    task automatic close_test(input string name, input bit ok);
        tests_run++;
        if (ok) begin
            $display("test %0d %s: PASS", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL", tests_run, name);
        end
    endtask

    // Data display follows the stored byte at every sample
    always @(negedge clk) begin
        if (arst_n === 1'b1 && data_seg !== seg_of(data_byte[3:0])) begin
            report_mismatch("data_seg", seg_of(data_byte[3:0]), data_seg);
            seg_errors++;
        end
    end

    // Reset with run low and the loader idle
    task automatic reset_dut();
        @(posedge clk);
        run     <= 1'b0;
        arst_n  <= 1'b0;
        load.we <= 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    // One strobe per word over the whole lower half
    task automatic load_image();
        int i;
        for (i = 0; i < PROG_WORDS; i++) begin
            @(posedge clk);
            load.we   <= 1'b1;
            load.addr <= 7'(i);
            load.data <= image[i];
        end
        @(posedge clk);
        load.we <= 1'b0;
    endtask

    // Random LDA/ADD/STA body over random filler and then the stop opcode
    task automatic build_program(input int n_instr, input logic [3:0] stop_opc);
        int         i;
        int         pc;
        logic [3:0] opc;
        logic [7:0] operand;
        for (i = 0; i < PROG_WORDS; i++) begin
            image[i] = 8'($urandom);
        end
        pc = 0;
        for (i = 0; i < n_instr; i++) begin
            case ($urandom_range(2))
                0: opc = 4'h1;
                1: opc = 4'h2;
                default: opc = 4'h3;
            endcase
            // Half the operands hit the data window
            if ($urandom_range(1) == 1) begin
                operand = 8'h80 | 8'($urandom);
            end else begin
                operand = {1'b0, 7'($urandom)};
            end
            image[pc]     = {opc, 4'($urandom)};
            image[pc + 1] = operand;
            pc += 2;
        end
        image[pc] = {stop_opc, 4'($urandom)};
    endtask

    // Directed program for the dropped lower-half STA and the upper alias
    task automatic alias_program_image();
        int i;
        for (i = 0; i < PROG_WORDS; i++) begin
            image[i] = 8'($urandom);
        end
        // Odd seed byte keeps x, 2x and 4x apart
        image[8'h40] = image[8'h40] | 8'h01;
        // Program words behind the aliased operands differ from the data byte
        image[8'h71] = ~image[8'h40];
        image[8'h25] = ~image[8'h40];
        image[0]  = 8'h2a;
        image[1]  = 8'h40;
        image[2]  = 8'h13;
        image[3]  = 8'h80 | 8'($urandom);
        image[4]  = 8'h21;
        image[5]  = 8'hf1;
        image[6]  = 8'h3c;
        image[7]  = 8'ha5;
        image[8]  = 8'h1e;
        image[9]  = 8'h9c;
        // Accumulator now differs from the data byte
        image[10] = 8'h3c;
        image[11] = 8'ha5;
        image[12] = 8'h17;
        image[13] = 8'h50;
        image[14] = 8'hf0;
    endtask

    // Instruction-set model with the opcode in the upper nibble
    task automatic model_run();
        int         step;
        logic [7:0] pc;
        logic [7:0] acc;
        logic [7:0] data;
        logic [7:0] opnd;
        logic [7:0] value;
        logic       done;
        pc   = 8'h00;
        acc  = 8'h00;
        data = 8'h00;
        done = 1'b0;
        for (step = 0; step < PROG_WORDS && !done; step++) begin
            opnd  = image[7'(pc + 8'd1)];
            value = opnd[7] ? data : image[opnd[6:0]];
            case (image[pc[6:0]][7:4])
                4'h1: data = opnd[7] ? acc : data;
                4'h2: acc = value;
                4'h3: acc = acc + value;
                default: done = 1'b1;
            endcase
            if (!done) begin
                pc = pc + 8'd2;
            end
        end
        exp_data    = data;
        exp_halt_pc = pc;
    endtask

    task automatic compare_at_halt();
        if (data_byte !== exp_data) report_mismatch("data_byte", exp_data, data_byte);
        if (halted !== 1'b1) report_mismatch("halted", 8'd1, {7'd0, halted});
        if (addr_msb !== 1'b0) report_mismatch("addr_msb", 8'd0, {7'd0, addr_msb});
        if (addr_seg !== seg_of(exp_halt_pc[3:0])) begin
            report_mismatch("addr_seg", seg_of(exp_halt_pc[3:0]), addr_seg);
        end
        if (state !== saci_pkg::FETCH) report_mismatch("state", saci_pkg::FETCH, state);
    endtask

    task automatic idle_test();
        int err_before;
        err_before = errors;
        reset_dut();
        // Word 0 is LDA, ADD or STA, so only run keeps the FSM in fetch
        build_program(4, 4'hf);
        load_image();
        @(negedge clk);
        if (state !== saci_pkg::FETCH) report_mismatch("state", saci_pkg::FETCH, state);
        if (data_byte !== 8'h00) report_mismatch("data_byte", 8'h00, data_byte);
        if (halted !== 1'b0) report_mismatch("halted", 8'd0, {7'd0, halted});
        // Sequencer must not move with run low
        repeat (10) begin
            @(negedge clk);
            if (state !== saci_pkg::FETCH) report_mismatch("state", saci_pkg::FETCH, state);
            // PC stays on word 0
            if (addr_seg !== seg_of(4'h0)) report_mismatch("addr_seg", seg_of(4'h0), addr_seg);
        end
        close_test("idle_after_reset", errors == err_before);
    endtask

    task automatic run_program(input string name, input int n_instr);
        int err_before;
        int cycles;
        int limit;
        err_before = errors;
        limit      = n_instr * 5 + 20;
        reset_dut();
        load_image();
        model_run();
        @(posedge clk);
        run <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (halted !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("Timeout: %s did not halt within %0d cycles", name, limit);
            errors++;
        end else begin
            compare_at_halt();
            // Halt sticks with the PC frozen on the halt word
            repeat (3) @(negedge clk);
            compare_at_halt();
        end
        close_test(name, errors == err_before);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        int         t;
        int         n;
        logic [3:0] bad_opc;
        arst_n       = 1'b0;
        run          = 1'b0;
        load         = '0;
        errors       = 0;
        seg_errors   = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h4185));

        idle_test();
        alias_program_image();
        run_program("sta_lower_lda_alias", 7);
        for (t = 0; t < 15; t++) begin
            n = $urandom_range(MAX_INSTR - 1, 1);
            build_program(n, 4'hf);
            run_program("random_program", n);
        end
        // Codes 0 and 4 to E are all undefined
        for (t = 0; t < 3; t++) begin
            n       = $urandom_range(MAX_INSTR - 1, 1);
            bad_opc = 4'($urandom_range(14, 3));
            if (bad_opc == 4'h3) begin
                bad_opc = 4'h0;
            end
            build_program(n, bad_opc);
            run_program($sformatf("unknown_opcode_%h", bad_opc), n);
        end
        close_test("data_seg_monitor", seg_errors == 0);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hw
hw/saci_pkg.sv
hw/saci_control.sv
hw/saci_datapath.sv
hw/saci_memory.sv
hw/saci_hex_display.sv
hw/saci_top.sv
sim/saci_tb.sv
